// ==== common/dbg_defines.svh ====
// Debug block widths and depths
// Fixed by the QPSK receiver and the GPIO word size
// Shared by RTL and testbench

`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

// ========================================
`define NBT_GPIOS    32   // GPIO command and readback word
`define NBT_FSE      8    // FSE input sample S(8,7)
`define NBT_SLCR     12   // Slicer input and error sample S(12,9)
`define NBT_TAPS     8    // Coefficient sample
`define NBT_BER_CNT  64   // One BER counter

`define LOG_DEPTH    1024 // Log RAM words
`define LOG_ADRS_W   10   // Log RAM address bits

`endif

// ==== common/dbg_pkg.sv ====
// Debug block types
// Host opcodes, log and BER selectors, probe bundle,
// BER counter bundle and log RAM request

`include "dbg_defines.svh"

package dbg_pkg;

	// ========================================
	// Host command opcodes, bits 31..24
	typedef enum logic [7:0] {
		OP_DSP_RESET   = 8'h01,
		OP_ADAPT       = 8'h02,
		OP_LOG         = 8'h03,
		OP_RAM_READ    = 8'h04,
		OP_BER_CAPTURE = 8'h05,
		OP_BER_READ    = 8'h06
	} opcode_e;

	// Stream to log
	typedef enum logic [2:0] {
		LOG_FSE   = 3'd0, // Rate 2
		LOG_SLCR  = 3'd1, // Rate 2
		LOG_COEFF = 3'd2, // Rate 1
		LOG_ERR   = 3'd3  // Rate 1
	} log_sel_e;

	// 32-bit half of a BER counter
	typedef enum logic [2:0] {
		BER_ERR_I_LO = 3'b000,
		BER_ERR_I_HI = 3'b001,
		BER_BIT_I_LO = 3'b010,
		BER_BIT_I_HI = 3'b011,
		BER_ERR_Q_LO = 3'b100,
		BER_ERR_Q_HI = 3'b101,
		BER_BIT_Q_LO = 3'b110,
		BER_BIT_Q_HI = 3'b111
	} ber_sel_e;

	// ========================================
	// Receiver probe points
	typedef struct packed {
		logic signed [`NBT_FSE-1:0]  fse_i;
		logic signed [`NBT_FSE-1:0]  fse_q;
		logic signed [`NBT_SLCR-1:0] slcr_i;
		logic signed [`NBT_SLCR-1:0] slcr_q;
		logic signed [`NBT_TAPS-1:0] coeff_i;
		logic signed [`NBT_TAPS-1:0] coeff_q;
		logic signed [`NBT_SLCR-1:0] err_i;
		logic signed [`NBT_SLCR-1:0] err_q;
		logic                        rate2; // Twice baud rate strobe
		logic                        rate1; // Baud rate strobe
	} dsp_probe_t;

	typedef struct packed {
		logic [`NBT_BER_CNT-1:0] err_i;
		logic [`NBT_BER_CNT-1:0] bit_i;
		logic [`NBT_BER_CNT-1:0] err_q;
		logic [`NBT_BER_CNT-1:0] bit_q;
	} ber_cnt_t;

	typedef struct packed {
		logic     wr_en;
		log_sel_e sel;
	} log_ctrl_t;

	// One access on the single RAM port
	typedef struct packed {
		logic                    valid;
		logic                    write;
		logic [`LOG_ADRS_W-1:0]  adrs;
		logic [`NBT_GPIOS-1:0]   wdata;
	} ram_req_t;

endpackage

// ==== host_regfile/host_regfile.sv ====
// Host register file
// Decodes strobed GPIO command words into the control registers
// and picks the word returned on the GPIO readback

`timescale 1ns/1ps

`include "dbg_defines.svh"

module host_regfile (
	input  logic                   clk,
	input  logic                   w_reset_from_vio,
	input  logic [`NBT_GPIOS-1:0]  i_gpio_cmd,
	output dbg_pkg::log_ctrl_t     o_log_ctrl,
	output logic [`LOG_ADRS_W-1:0] o_rd_adrs,
	output logic                   o_rd_en,
	output logic                   o_ber_capture,
	output dbg_pkg::ber_sel_e      o_ber_sel,
	input  logic [`NBT_GPIOS-1:0]  i_ram_rd_data,
	input  logic [`NBT_GPIOS-1:0]  i_ber_word,
	output logic [`NBT_GPIOS-1:0]  o_gpio_rd,
	output logic                   o_dsp_reset,
	output logic                   o_adapt_en
);

	// ========================================
	// Command word fields
	dbg_pkg::opcode_e       w_op;
	logic                   w_strobe;

	logic                   r_dsp_reset;
	logic                   r_adapt_en;
	dbg_pkg::log_ctrl_t     r_log_ctrl;
	logic [`LOG_ADRS_W-1:0] r_rd_adrs;
	logic                   r_rd_en;
	logic                   r_ber_capture;
	dbg_pkg::ber_sel_e      r_ber_sel;
	logic                   r_ber_rd_en;

	assign w_op     = dbg_pkg::opcode_e'(i_gpio_cmd[31:24]);
	assign w_strobe = i_gpio_cmd[23]; // Command valid while high

	// ========================================
	// Control registers, one edge after the command cycle
	always_ff @(posedge clk) begin
		if (w_reset_from_vio) begin
			r_dsp_reset      <= 1'b1;            // DSP held in reset
			r_adapt_en       <= 1'b0;
			r_log_ctrl.wr_en <= 1'b0;
			r_log_ctrl.sel   <= dbg_pkg::LOG_FSE;
			r_rd_adrs        <= '0;
			r_rd_en          <= 1'b0;
			r_ber_capture    <= 1'b0;
			r_ber_sel        <= dbg_pkg::BER_ERR_I_LO;
			r_ber_rd_en      <= 1'b0;
		end else if (w_strobe) begin
			case (w_op)
				dbg_pkg::OP_DSP_RESET: r_dsp_reset <= i_gpio_cmd[0];
				dbg_pkg::OP_ADAPT:     r_adapt_en  <= i_gpio_cmd[0];
				dbg_pkg::OP_LOG: begin
					r_log_ctrl.sel   <= dbg_pkg::log_sel_e'(i_gpio_cmd[2:0]);
					r_log_ctrl.wr_en <= i_gpio_cmd[3];
				end
				dbg_pkg::OP_RAM_READ: begin
					r_rd_adrs <= i_gpio_cmd[`LOG_ADRS_W-1:0]; // Held static for reads
					r_rd_en   <= i_gpio_cmd[16];
				end
				dbg_pkg::OP_BER_CAPTURE: r_ber_capture <= i_gpio_cmd[0];
				dbg_pkg::OP_BER_READ: begin
					r_ber_sel   <= dbg_pkg::ber_sel_e'(i_gpio_cmd[2:0]);
					r_ber_rd_en <= i_gpio_cmd[3];
				end
				default: ; // Unknown opcode ignored
			endcase
		end
	end

	// ========================================
	// Readback, RAM first then BER half
	always_comb begin
		if (r_rd_en)
			o_gpio_rd = i_ram_rd_data;
		else if (r_ber_rd_en)
			o_gpio_rd = i_ber_word;
		else
			o_gpio_rd = '0;
	end

	assign o_log_ctrl    = r_log_ctrl;
	assign o_rd_adrs     = r_rd_adrs;
	assign o_rd_en       = r_rd_en;
	assign o_ber_capture = r_ber_capture;
	assign o_ber_sel     = r_ber_sel;
	assign o_dsp_reset   = r_dsp_reset;
	assign o_adapt_en    = r_adapt_en;

endmodule

// ==== log_ram/log_capture.sv ====
// Probe stream logger
// Picks one receiver stream and its rate strobe, packs I and Q
// sign-extended into a 32-bit word and writes it to the log RAM
// from address 0 until the RAM is full

`timescale 1ns/1ps

`include "dbg_defines.svh"

module log_capture (
	input  logic                clk,
	input  logic                w_reset_from_vio,
	input  dbg_pkg::log_ctrl_t  i_log_ctrl,
	input  dbg_pkg::dsp_probe_t i_probe,
	output dbg_pkg::ram_req_t   o_wr_req
);

	localparam int HALF_W = `NBT_GPIOS / 2; // One lane per I and Q

	logic                   r_wr_en_d;  // Enable last cycle
	logic [`LOG_ADRS_W:0]   r_wr_cnt;   // Words written, one extra bit for full
	logic                   r_wr_valid;
	logic [`LOG_ADRS_W-1:0] r_wr_adrs;
	logic [`NBT_GPIOS-1:0]  r_wr_data;

	logic                   w_rise;
	logic [`LOG_ADRS_W:0]   w_base;
	logic                   w_full;
	logic                   w_strobe;
	logic [HALF_W-1:0]      w_lane_i;
	logic [HALF_W-1:0]      w_lane_q;
	logic                   w_fire;

	// ========================================
	// Stream select and sign extension
	always_comb begin
		w_strobe = 1'b0;
		w_lane_i = '0;
		w_lane_q = '0;
		case (i_log_ctrl.sel)
			dbg_pkg::LOG_FSE: begin
				w_strobe = i_probe.rate2;
				w_lane_i = {{(HALF_W-`NBT_FSE){i_probe.fse_i[`NBT_FSE-1]}}, i_probe.fse_i};
				w_lane_q = {{(HALF_W-`NBT_FSE){i_probe.fse_q[`NBT_FSE-1]}}, i_probe.fse_q};
			end
			dbg_pkg::LOG_SLCR: begin
				w_strobe = i_probe.rate2;
				w_lane_i = {{(HALF_W-`NBT_SLCR){i_probe.slcr_i[`NBT_SLCR-1]}}, i_probe.slcr_i};
				w_lane_q = {{(HALF_W-`NBT_SLCR){i_probe.slcr_q[`NBT_SLCR-1]}}, i_probe.slcr_q};
			end
			dbg_pkg::LOG_COEFF: begin
				w_strobe = i_probe.rate1;
				w_lane_i = {{(HALF_W-`NBT_TAPS){i_probe.coeff_i[`NBT_TAPS-1]}}, i_probe.coeff_i};
				w_lane_q = {{(HALF_W-`NBT_TAPS){i_probe.coeff_q[`NBT_TAPS-1]}}, i_probe.coeff_q};
			end
			dbg_pkg::LOG_ERR: begin
				w_strobe = i_probe.rate1;
				w_lane_i = {{(HALF_W-`NBT_SLCR){i_probe.err_i[`NBT_SLCR-1]}}, i_probe.err_i};
				w_lane_q = {{(HALF_W-`NBT_SLCR){i_probe.err_q[`NBT_SLCR-1]}}, i_probe.err_q};
			end
			default: ; // Unused codes log nothing
		endcase
	end

	// Restart at address 0 on a new enable
	assign w_rise = i_log_ctrl.wr_en & ~r_wr_en_d;
	assign w_base = w_rise ? '0 : r_wr_cnt;
	assign w_full = (w_base == (`LOG_ADRS_W+1)'(`LOG_DEPTH));
	assign w_fire = i_log_ctrl.wr_en & w_strobe & ~w_full;

	// ========================================
	always_ff @(posedge clk) begin
		if (w_reset_from_vio) begin
			r_wr_en_d  <= 1'b0;
			r_wr_cnt   <= '0;
			r_wr_valid <= 1'b0;
		end else begin
			r_wr_en_d  <= i_log_ctrl.wr_en;
			r_wr_valid <= w_fire;
			r_wr_cnt   <= w_fire ? w_base + 1'b1 : w_base; // Stops at full
		end
	end

	// Write payload
	always_ff @(posedge clk) begin
		if (w_fire) begin
			r_wr_adrs <= w_base[`LOG_ADRS_W-1:0];
			r_wr_data <= {w_lane_i, w_lane_q};
		end
	end

	assign o_wr_req = '{valid: r_wr_valid, write: r_wr_valid,
		adrs: r_wr_adrs, wdata: r_wr_data};

endmodule

// ==== log_ram/log_ram_arbiter.sv ====
// Log RAM port arbiter
// Writer always wins, host read takes every free cycle
// Read word is registered only for cycles granted to the host

`timescale 1ns/1ps

`include "dbg_defines.svh"

module log_ram_arbiter (
	input  logic                   clk,
	input  logic                   w_reset_from_vio,
	input  dbg_pkg::ram_req_t      i_wr_req,
	input  logic [`LOG_ADRS_W-1:0] i_rd_adrs,
	input  logic                   i_rd_en,
	output dbg_pkg::ram_req_t      o_mem_req,
	input  logic [`NBT_GPIOS-1:0]  i_mem_rd_data,
	output logic [`NBT_GPIOS-1:0]  o_rd_data
);

	logic                  w_host_grant;
	logic                  r_rd_pend;  // Memory data belongs to host this cycle
	logic [`NBT_GPIOS-1:0] r_rd_data;

	// ========================================
	// Port grant
	assign w_host_grant = i_rd_en & ~i_wr_req.valid;

	always_comb begin
		if (i_wr_req.valid) begin
			o_mem_req = i_wr_req;
		end else begin
			// Host read, no handshake since address is static
			o_mem_req.valid = i_rd_en;
			o_mem_req.write = 1'b0;
			o_mem_req.adrs  = i_rd_adrs;
			o_mem_req.wdata = '0;
		end
	end

	// ========================================
	// Read return path
	always_ff @(posedge clk) begin
		if (w_reset_from_vio)
			r_rd_pend <= 1'b0;
		else
			r_rd_pend <= w_host_grant;
	end

	always_ff @(posedge clk) begin
		if (r_rd_pend)
			r_rd_data <= i_mem_rd_data; // Held through write stalls
	end

	assign o_rd_data = r_rd_data;

endmodule

// ==== log_ram/log_mem.sv ====
// Log memory
// Single-port RAM of LOG_DEPTH 32-bit words, registered read

`timescale 1ns/1ps

`include "dbg_defines.svh"

module log_mem (
	input  logic                  clk,
	input  dbg_pkg::ram_req_t     i_mem_req,
	output logic [`NBT_GPIOS-1:0] o_rd_data
);

	logic [`NBT_GPIOS-1:0] r_mem [`LOG_DEPTH];
	logic [`NBT_GPIOS-1:0] r_rd_data;

	// One access per cycle
	always_ff @(posedge clk) begin
		if (i_mem_req.valid) begin
			if (i_mem_req.write)
				r_mem[i_mem_req.adrs] <= i_mem_req.wdata;
			else
				r_rd_data <= r_mem[i_mem_req.adrs]; // Read output holds on writes
		end
	end

	assign o_rd_data = r_rd_data;

endmodule

// ==== ber/ber_snapshot.sv ====
// BER counter snapshot
// Tracks the four live counters while capture is set, freezes
// them when it clears, and returns one registered 32-bit half

`timescale 1ns/1ps

`include "dbg_defines.svh"

module ber_snapshot (
	input  logic                  clk,
	input  logic                  w_reset_from_vio,
	input  dbg_pkg::ber_cnt_t     i_ber_cnt,
	input  logic                  i_capture,
	input  dbg_pkg::ber_sel_e     i_sel,
	output logic [`NBT_GPIOS-1:0] o_ber_word
);

	dbg_pkg::ber_cnt_t     r_snap;
	logic [`NBT_GPIOS-1:0] r_ber_word;
	logic [`NBT_GPIOS-1:0] w_half;

	// ========================================
	always_ff @(posedge clk) begin
		if (w_reset_from_vio)
			r_snap <= '0;
		else if (i_capture)
			r_snap <= i_ber_cnt; // Copy every cycle, frozen otherwise
	end

	// Half select
	always_comb begin
		case (i_sel)
			dbg_pkg::BER_ERR_I_LO: w_half = r_snap.err_i[`NBT_GPIOS-1:0];
			dbg_pkg::BER_ERR_I_HI: w_half = r_snap.err_i[`NBT_BER_CNT-1:`NBT_GPIOS];
			dbg_pkg::BER_BIT_I_LO: w_half = r_snap.bit_i[`NBT_GPIOS-1:0];
			dbg_pkg::BER_BIT_I_HI: w_half = r_snap.bit_i[`NBT_BER_CNT-1:`NBT_GPIOS];
			dbg_pkg::BER_ERR_Q_LO: w_half = r_snap.err_q[`NBT_GPIOS-1:0];
			dbg_pkg::BER_ERR_Q_HI: w_half = r_snap.err_q[`NBT_BER_CNT-1:`NBT_GPIOS];
			dbg_pkg::BER_BIT_Q_LO: w_half = r_snap.bit_q[`NBT_GPIOS-1:0];
			default:               w_half = r_snap.bit_q[`NBT_BER_CNT-1:`NBT_GPIOS];
		endcase
	end

	always_ff @(posedge clk) begin
		if (w_reset_from_vio)
			r_ber_word <= '0;
		else
			r_ber_word <= w_half; // Second cycle after the read command
	end

	assign o_ber_word = r_ber_word;

endmodule

// ==== src/dbg_top.sv ====
// Debug and logging block top level
// GPIO command decode, probe logging into the log RAM,
// RAM readback and BER counter snapshot

`timescale 1ns/1ps

`include "dbg_defines.svh"

module dbg_top (
	input  logic                  clk,
	input  logic                  w_reset_from_vio,
	input  logic [`NBT_GPIOS-1:0] i_gpio_cmd,     // From host
	output logic [`NBT_GPIOS-1:0] o_gpio_rd,      // To host
	input  dbg_pkg::dsp_probe_t   i_probe,        // Receiver probes
	input  dbg_pkg::ber_cnt_t     i_ber_cnt,      // Live BER counters
	output logic                  o_dsp_reset,
	output logic                  o_adapt_en
);

	// ========================================
	dbg_pkg::log_ctrl_t      w_log_ctrl;
	logic [`LOG_ADRS_W-1:0]  w_rd_adrs;
	logic                    w_rd_en;
	logic                    w_ber_capture;
	dbg_pkg::ber_sel_e       w_ber_sel;
	logic [`NBT_GPIOS-1:0]   w_ram_rd_data;  // Registered in arbiter
	logic [`NBT_GPIOS-1:0]   w_mem_rd_data;  // Straight from memory
	logic [`NBT_GPIOS-1:0]   w_ber_word;
	dbg_pkg::ram_req_t       w_wr_req;
	dbg_pkg::ram_req_t       w_mem_req;

	// ========================================
	host_regfile u_host_regfile (
		.clk              (clk),
		.w_reset_from_vio (w_reset_from_vio),
		.i_gpio_cmd       (i_gpio_cmd),
		.o_log_ctrl       (w_log_ctrl),
		.o_rd_adrs        (w_rd_adrs),
		.o_rd_en          (w_rd_en),
		.o_ber_capture    (w_ber_capture),
		.o_ber_sel        (w_ber_sel),
		.i_ram_rd_data    (w_ram_rd_data),
		.i_ber_word       (w_ber_word),
		.o_gpio_rd        (o_gpio_rd),
		.o_dsp_reset      (o_dsp_reset),
		.o_adapt_en       (o_adapt_en)
	);

	log_capture u_log_capture (
		.clk              (clk),
		.w_reset_from_vio (w_reset_from_vio),
		.i_log_ctrl       (w_log_ctrl),
		.i_probe          (i_probe),
		.o_wr_req         (w_wr_req)
	);

	log_ram_arbiter u_log_ram_arbiter (
		.clk              (clk),
		.w_reset_from_vio (w_reset_from_vio),
		.i_wr_req         (w_wr_req),
		.i_rd_adrs        (w_rd_adrs),
		.i_rd_en          (w_rd_en),
		.o_mem_req        (w_mem_req),
		.i_mem_rd_data    (w_mem_rd_data),
		.o_rd_data        (w_ram_rd_data)
	);

	log_mem u_log_mem (
		.clk       (clk),
		.i_mem_req (w_mem_req),
		.o_rd_data (w_mem_rd_data)
	);

	ber_snapshot u_ber_snapshot (
		.clk              (clk),
		.w_reset_from_vio (w_reset_from_vio),
		.i_ber_cnt        (i_ber_cnt),
		.i_capture        (w_ber_capture),
		.i_sel            (w_ber_sel),
		.o_ber_word       (w_ber_word)
	);

endmodule

// ==== testbench/tb_dbg_top.sv ====
// Testbench for the debug and logging block
// Runs the command, probe, BER and readback records of the input
// data file and stops at the first wrong readback

`timescale 1ns/1ps

`include "dbg_defines.svh"

module tb_dbg_top;

	localparam int WAIT_LIMIT  = 64;    // Longest wait any record may ask for
	localparam int MAX_RECORDS = 4096;  // Guards the file loop

	logic                  clk;
	logic                  w_reset_from_vio;
	logic [`NBT_GPIOS-1:0] i_gpio_cmd;
	logic [`NBT_GPIOS-1:0] o_gpio_rd;
	dbg_pkg::dsp_probe_t   probe;
	dbg_pkg::ber_cnt_t     ber_cnt;
	logic                  o_dsp_reset;
	logic                  o_adapt_en;

	int                    fd;
	int                    n;
	int                    rec;
	int                    lat;
	logic                  done;
	logic [8*8-1:0]        kind;       // Record letter
	logic [8*200-1:0]      line;       // Rest of a comment line
	logic [63:0]           f [10];     // Hex fields of one record

	dbg_top i_dut (
		.clk              (clk),
		.w_reset_from_vio (w_reset_from_vio),
		.i_gpio_cmd       (i_gpio_cmd),
		.o_gpio_rd        (o_gpio_rd),
		.i_probe          (probe),
		.i_ber_cnt        (ber_cnt),
		.o_dsp_reset      (o_dsp_reset),
		.o_adapt_en       (o_adapt_en)
	);

	// 100 ns clock
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ========================================
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Checks failed");
		$fatal(1, "run stopped");
	endtask

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual);
			abort_run("Readback mismatch");
		end
	endtask

	// Falling edges, bounded
	task automatic wait_falling(input int cycles);
		int k;
		if (cycles > WAIT_LIMIT) begin
			abort_run("A record asks for a wait longer than the cycle limit");
		end else begin
			for (k = 0; k < cycles; k++)
				@(negedge clk);
		end
	endtask

	// One strobed cycle, then an idle word
	task automatic send_cmd(input logic [31:0] cmd);
		i_gpio_cmd = cmd;
		wait_falling(1);
		i_gpio_cmd = '0;
	endtask

	task automatic drive_probe();
		probe.rate2   = f[0][0];
		probe.rate1   = f[1][0];
		probe.fse_i   = f[2][`NBT_FSE-1:0];
		probe.fse_q   = f[3][`NBT_FSE-1:0];
		probe.slcr_i  = f[4][`NBT_SLCR-1:0];
		probe.slcr_q  = f[5][`NBT_SLCR-1:0];
		probe.coeff_i = f[6][`NBT_TAPS-1:0];
		probe.coeff_q = f[7][`NBT_TAPS-1:0];
		probe.err_i   = f[8][`NBT_SLCR-1:0];
		probe.err_q   = f[9][`NBT_SLCR-1:0];
		wait_falling(1);
		probe.rate2 = 1'b0;  // Strobes last one cycle
		probe.rate1 = 1'b0;
	endtask

	// Command, fixed latency, then compare
	task automatic check_readback(input logic [31:0] cmd, input int cycles,
		input logic [31:0] expected);
		send_cmd(cmd);
		wait_falling(cycles - 1);
		compare("o_gpio_rd", expected, o_gpio_rd);
	endtask

	// ========================================
	initial begin
		done             = 1'b0;
		w_reset_from_vio = 1'b1;
		i_gpio_cmd       = '0;
		probe            = '0;
		ber_cnt          = '0;
		wait_falling(16);          // Reset held 16 cycles
		w_reset_from_vio = 1'b0;
		wait_falling(1);

		fd = $fopen("testbench/dbg_input.txt", "r");
		if (fd == 0)
			abort_run("Cannot open testbench/dbg_input.txt");

		for (rec = 0; rec < MAX_RECORDS && !done; rec++) begin
			n = $fscanf(fd, "%s", kind);
			if (n != 1) begin
				done = 1'b1;       // End of file
			end else if (kind == "#") begin
				n = $fgets(line, fd);
			end else if (kind == "C") begin
				n = $fscanf(fd, "%h", f[0]);
				if (n != 1)
					abort_run("Command record has no command word");
				send_cmd(f[0][31:0]);
			end else if (kind == "P") begin
				n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
				if (n != 10)
					abort_run("Probe record has too few fields");
				drive_probe();
			end else if (kind == "B") begin
				n = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
				if (n != 4)
					abort_run("BER record has too few fields");
				ber_cnt = '{err_i: f[0], bit_i: f[1], err_q: f[2], bit_q: f[3]};
			end else if (kind == "S") begin
				n = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
				if (n != 3)
					abort_run("Status record has too few fields");
				compare("o_dsp_reset", f[0][31:0], {31'b0, o_dsp_reset});
				compare("o_adapt_en", f[1][31:0], {31'b0, o_adapt_en});
				compare("o_gpio_rd", f[2][31:0], o_gpio_rd);
			end else if (kind == "R") begin
				n = $fscanf(fd, "%h %d %h", f[0], lat, f[1]);
				if (n != 3)
					abort_run("Readback record has too few fields");
				check_readback(f[0][31:0], lat, f[1][31:0]);
			end else begin
				abort_run("Unknown record kind in the input file");
			end
		end
		$fclose(fd);

		if (!done) begin
			abort_run("Input file has more records than the loop allows");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

// ==== testbench/dbg_input.txt ====
# C cmd | S dsp_reset adapt_en gpio_rd | B err_i bit_i err_q bit_q | R cmd latency expected
# P rate2 rate1 fse_i fse_q slcr_i slcr_q coeff_i coeff_q err_i err_q
S 1 0 00000000
C 01800000
C 02800001
S 0 1 00000000
# FSE stream at rate 2
C 03800008
P 1 0 7F 80 000 000 00 00 000 000
P 0 1 55 66 000 000 00 00 000 000
P 1 0 C3 25 000 000 00 00 000 000
P 0 1 11 22 000 000 00 00 000 000
P 1 0 01 FE 000 000 00 00 000 000
C 03800000
R 04810000 3 007FFF80
R 04810001 3 FFC30025
R 04810002 3 0001FFFE
# Coefficients at rate 1, restart at 0
C 0380000A
P 1 0 00 00 000 000 33 44 000 000
P 0 1 00 00 000 000 9A 12 000 000
P 1 0 00 00 000 000 55 66 000 000
P 0 1 00 00 000 000 40 F1 000 000
C 03800000
R 04810000 3 FF9A0012
R 04810001 3 0040FFF1
R 04810002 3 0001FFFE
# Error samples at rate 1
C 0380000B
P 0 1 00 00 000 000 00 00 800 7FF
P 1 0 00 00 000 000 00 00 111 222
P 0 1 00 00 000 000 00 00 123 ABC
C 03800000
R 04810000 3 F80007FF
R 04810001 3 0123FABC
# BER snapshot, then live counters move
C 04800000
B 0000001122334455 000000ABCDEF0123 0000000000000099 0123456789ABCDEF
C 05800001
C 05800000
B FFFFFFFFFFFFFFFF 1111111111111111 2222222222222222 3333333333333333
R 06800008 2 22334455
R 06800009 2 00000011
R 0680000A 2 CDEF0123
R 0680000B 2 000000AB
R 0680000C 2 00000099
R 0680000D 2 00000000
R 0680000E 2 89ABCDEF
R 0680000F 2 01234567
# Readback priority and unstrobed words
R 04810000 3 F80007FF
C 04800000
C 06800000
R 04010000 2 00000000
C 01000001
S 0 1 00000000

// ==== files.f ====
+incdir+common
common/dbg_pkg.sv
host_regfile/host_regfile.sv
log_ram/log_capture.sv
log_ram/log_ram_arbiter.sv
log_ram/log_mem.sv
ber/ber_snapshot.sv
src/dbg_top.sv
testbench/tb_dbg_top.sv

// ==== Bender.yml ====
package:
  name: dbg_top

sources:
  - include_dirs:
      - common
    files:
      - common/dbg_pkg.sv
      - host_regfile/host_regfile.sv
      - log_ram/log_capture.sv
      - log_ram/log_ram_arbiter.sv
      - log_ram/log_mem.sv
      - ber/ber_snapshot.sv
      - src/dbg_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_dbg_top.sv
